//--- Makefile
TOOL       = verilator
FLAGS      = --binary --timing --assert
LINT_FLAGS = --lint-only --timing
TOP        = rs_tb
FILELIST   = src.f
OBJDIR     = obj_dir
PASS_MSG   = *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Exit status comes from the search for the pass line
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJDIR)

//--- source/alu_unit.sv
// Module alu_unit, two-stage ALU whose second stage drives the CDB
`timescale 1ns/1ns

module alu_unit import rs_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      issue_valid,
    input  alu_func_t issue_func,
    input  rob_tag_t  issue_tag,
    input  data_t     issue_opa,
    input  data_t     issue_opb,
    output logic      cdb_valid,   // One-cycle result broadcast
    output rob_tag_t  cdb_tag,
    output data_t     cdb_value
);

    data_t    result;    // Stage 1 combinational value
    logic     s1_valid;
    rob_tag_t s1_tag;
    data_t    s1_value;

    //////////////////////////////////////////////////
    // Stage 1, evaluate
    //////////////////////////////////////////////////

    always_comb begin
        case (issue_func)
            ALU_ADD: result = issue_opa + issue_opb;
            ALU_SUB: result = issue_opa - issue_opb;
            ALU_AND: result = issue_opa & issue_opb;
            ALU_OR:  result = issue_opa | issue_opb;
            ALU_XOR: result = issue_opa ^ issue_opb;
            ALU_SLL: result = issue_opa << issue_opb[4:0];   // Low 5 bits only
            ALU_SRL: result = issue_opa >> issue_opb[4:0];
            ALU_SLT: result = data_t'($signed(issue_opa) < $signed(issue_opb));
            default: result = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) s1_valid <= 1'b0;
        else       s1_valid <= issue_valid;
    end

    always_ff @(posedge clock) begin
        s1_tag   <= issue_tag;
        s1_value <= result;
    end

    //////////////////////////////////////////////////
    // Stage 2, CDB register
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) cdb_valid <= 1'b0;
        else       cdb_valid <= s1_valid;
    end

    always_ff @(posedge clock) begin
        cdb_tag   <= s1_tag;
        cdb_value <= s1_value;
    end

endmodule

//--- source/rs_alloc.sv
// Module rs_alloc, dispatch acceptance, lowest-free entry pick and CDB bypass
`timescale 1ns/1ns
`include "rs_consts.svh"

module rs_alloc import rs_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       dispatch_valid,     // Op offered
    input  logic       dispatch_opa_valid, // A is a value
    input  logic       dispatch_opb_valid, // B is a value
    input  alu_func_t  dispatch_func,
    input  rob_tag_t   dispatch_tag,
    input  data_t      dispatch_opa,
    input  data_t      dispatch_opb,
    output logic       dispatch_ready,     // Some entry free
    input  logic       cdb_valid,
    input  rob_tag_t   cdb_tag,
    input  data_t      cdb_value,
    rs_load_if.alloc   load_bus,
    input  entry_vec_t free                // Empty entries
);

    entry_vec_t lowest_free;  // Lowest set bit of free
    logic       accept;       // Handshake completes this edge
    logic       hit_a;        // Operand A produced on CDB now
    logic       hit_b;        // Operand B produced on CDB now

    assign dispatch_ready = |free;  // Independent of dispatch_valid
    assign accept         = dispatch_valid && dispatch_ready;
    assign lowest_free    = free & (~free + entry_vec_t'(1));  // Isolate lowest one

    // A waiting operand whose producer broadcasts this cycle would miss it
    assign hit_a = cdb_valid && !dispatch_opa_valid
                   && (cdb_tag == dispatch_opa[`RS_TAG_BITS-1:0]);
    assign hit_b = cdb_valid && !dispatch_opb_valid
                   && (cdb_tag == dispatch_opb[`RS_TAG_BITS-1:0]);

    assign load_bus.load      = accept ? lowest_free : '0;
    assign load_bus.func      = dispatch_func;
    assign load_bus.tag       = dispatch_tag;
    assign load_bus.opa       = hit_a ? cdb_value : dispatch_opa;  // Bypass value
    assign load_bus.opa_valid = dispatch_opa_valid || hit_a;
    assign load_bus.opb       = hit_b ? cdb_value : dispatch_opb;
    assign load_bus.opb_valid = dispatch_opb_valid || hit_b;

    // Loaded slot must read busy in the next cycle
    a_load_on_free : assert property (
        @(posedge clock) disable iff (reset) |load_bus.load |=> (free & $past(load_bus.load)) == '0
    ) else $error("rs_alloc: loaded entry still free after load");

endmodule

//--- source/rs_cluster.sv
// Module rs_cluster, top level of allocator, entry array, issue selector and ALU
`timescale 1ns/1ns
`include "rs_consts.svh"

module rs_cluster import rs_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      dispatch_valid,
    input  logic      dispatch_opa_valid,
    input  logic      dispatch_opb_valid,
    input  alu_func_t dispatch_func,
    input  rob_tag_t  dispatch_tag,
    input  data_t     dispatch_opa,
    input  data_t     dispatch_opb,
    output logic      dispatch_ready,
    output logic      complete_valid,   // CDB broadcast, no back-pressure
    output rob_tag_t  complete_tag,
    output data_t     complete_value
);

    logic      cdb_valid;
    rob_tag_t  cdb_tag;
    data_t     cdb_value;

    logic      issue_valid;  // Selector to ALU
    alu_func_t issue_func;
    rob_tag_t  issue_tag;
    data_t     issue_opa;
    data_t     issue_opb;

    rs_load_if  load_bus ();
    rs_issue_if issue_bus ();

    //////////////////////////////////////////////////
    // Dispatch side
    //////////////////////////////////////////////////

    rs_alloc u_alloc (
        .clock              (clock),
        .reset              (reset),
        .dispatch_valid     (dispatch_valid),
        .dispatch_opa_valid (dispatch_opa_valid),
        .dispatch_opb_valid (dispatch_opb_valid),
        .dispatch_func      (dispatch_func),
        .dispatch_tag       (dispatch_tag),
        .dispatch_opa       (dispatch_opa),
        .dispatch_opb       (dispatch_opb),
        .dispatch_ready     (dispatch_ready),
        .cdb_valid          (cdb_valid),
        .cdb_tag            (cdb_tag),
        .cdb_value          (cdb_value),
        .load_bus           (load_bus),
        .free               (issue_bus.free)
    );

    for (genvar i = 0; i < `RS_ENTRIES; i++) begin : g_entry
        rs_entry #(.SLOT(i)) u_entry (
            .clock     (clock),
            .reset     (reset),
            .load_bus  (load_bus),
            .issue_bus (issue_bus),
            .cdb_valid (cdb_valid),
            .cdb_tag   (cdb_tag),
            .cdb_value (cdb_value)
        );
    end

    //////////////////////////////////////////////////
    // Issue and execute
    //////////////////////////////////////////////////

    rs_issue u_issue (
        .clock       (clock),
        .reset       (reset),
        .issue_bus   (issue_bus),
        .issue_valid (issue_valid),
        .issue_func  (issue_func),
        .issue_tag   (issue_tag),
        .issue_opa   (issue_opa),
        .issue_opb   (issue_opb)
    );

    alu_unit u_alu (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_func  (issue_func),
        .issue_tag   (issue_tag),
        .issue_opa   (issue_opa),
        .issue_opb   (issue_opb),
        .cdb_valid   (cdb_valid),
        .cdb_tag     (cdb_tag),
        .cdb_value   (cdb_value)
    );

    assign complete_valid = cdb_valid;  // CDB is the completion path
    assign complete_tag   = cdb_tag;
    assign complete_value = cdb_value;

endmodule

//--- source/rs_consts.svh
// Sizing macros for the reservation-station cluster
`ifndef RS_CONSTS_SVH
`define RS_CONSTS_SVH

//////////////////////////////////////////////////
// Structure sizes
//////////////////////////////////////////////////

`define RS_ENTRIES   4   // Reservation-station entries, 2, 4 or 8

//////////////////////////////////////////////////
// Field widths
//////////////////////////////////////////////////

`define RS_TAG_BITS  4   // Destination and source tag width
`define RS_DATA_BITS 32  // Operand and result width
`define RS_FUNC_BITS 3   // ALU function code width

`endif

//--- source/rs_entry.sv
// Module rs_entry, one reservation-station slot with operand capture and CDB snoop
`timescale 1ns/1ns
`include "rs_consts.svh"

module rs_entry import rs_pkg::*; #(
    parameter int SLOT = 0  // Position in the load and issue vectors
) (
    input  logic      clock,
    input  logic      reset,
    rs_load_if.entry  load_bus,
    rs_issue_if.entry issue_bus,
    input  logic      cdb_valid,
    input  rob_tag_t  cdb_tag,
    input  data_t     cdb_value
);

    //////////////////////////////////////////////////
    // Entry state
    //////////////////////////////////////////////////

    logic      in_use;     // Holds an op
    logic      opa_valid;  // A captured
    logic      opb_valid;  // B captured
    data_t     opa;
    data_t     opb;
    rob_tag_t  opa_tag;    // Producer of A while waiting
    rob_tag_t  opb_tag;    // Producer of B while waiting
    rob_tag_t  dest_tag;
    alu_func_t func;

    logic      load;       // Our load strobe
    logic      grant;      // Our grant, frees the slot
    logic      snoop_a;    // CDB carries A now
    logic      snoop_b;    // CDB carries B now

    assign load    = load_bus.load[SLOT];
    assign grant   = issue_bus.grant[SLOT];
    assign snoop_a = cdb_valid && in_use && !opa_valid && (cdb_tag == opa_tag);
    assign snoop_b = cdb_valid && in_use && !opb_valid && (cdb_tag == opb_tag);

    // Status and payload toward the selector
    assign issue_bus.free[SLOT]  = !in_use;
    assign issue_bus.ready[SLOT] = in_use && opa_valid && opb_valid;
    assign issue_bus.func[SLOT]  = func;
    assign issue_bus.tag[SLOT]   = dest_tag;
    assign issue_bus.opa[SLOT]   = opa;
    assign issue_bus.opb[SLOT]   = opb;

    //////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            in_use    <= 1'b0;
            opa_valid <= 1'b0;
            opb_valid <= 1'b0;
        end else if (load) begin
            in_use    <= 1'b1;
            opa_valid <= load_bus.opa_valid;
            opb_valid <= load_bus.opb_valid;
        end else if (grant) begin
            in_use    <= 1'b0;  // Issued, slot empty next cycle
            opa_valid <= 1'b0;
            opb_valid <= 1'b0;
        end else begin
            if (snoop_a) opa_valid <= 1'b1;
            if (snoop_b) opb_valid <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Payload
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (load) begin
            func     <= load_bus.func;
            dest_tag <= load_bus.tag;
            opa      <= load_bus.opa;
            opb      <= load_bus.opb;
            opa_tag  <= load_bus.opa[`RS_TAG_BITS-1:0];  // Meaningful only when waiting
            opb_tag  <= load_bus.opb[`RS_TAG_BITS-1:0];
        end else begin
            if (snoop_a) opa <= cdb_value;
            if (snoop_b) opb <= cdb_value;
        end
    end

    // Allocator must see this slot as busy once loaded
    a_no_load_busy : assert property (
        @(posedge clock) disable iff (reset) load |-> !in_use
    ) else $error("rs_entry %0d: loaded while in use", SLOT);

    // Selector may only pick a slot with both operands present
    a_grant_ready : assert property (
        @(posedge clock) disable iff (reset) grant |-> (in_use && opa_valid && opb_valid)
    ) else $error("rs_entry %0d: granted while not ready", SLOT);

endmodule

//--- source/rs_if.sv
// Interfaces rs_load_if and rs_issue_if with their modports
`timescale 1ns/1ns
`include "rs_consts.svh"

//////////////////////////////////////////////////
// Allocator to entries
//////////////////////////////////////////////////

interface rs_load_if import rs_pkg::*; ();
    entry_vec_t load;       // One-hot or zero, write strobe per entry
    alu_func_t  func;       // Function of the dispatched op
    rob_tag_t   tag;        // Destination tag
    data_t      opa;        // Value, or source tag in low bits
    logic       opa_valid;  // Operand A holds a value
    data_t      opb;        // Value, or source tag in low bits
    logic       opb_valid;  // Operand B holds a value

    modport alloc (output load, func, tag, opa, opa_valid, opb, opb_valid);
    modport entry (input  load, func, tag, opa, opa_valid, opb, opb_valid);
endinterface

//////////////////////////////////////////////////
// Entries to issue selector
//////////////////////////////////////////////////

interface rs_issue_if import rs_pkg::*; ();
    entry_vec_t ready;                // In use with both operands valid
    entry_vec_t free;                 // Entry empty
    alu_func_t  func [`RS_ENTRIES];   // Per-entry function
    rob_tag_t   tag  [`RS_ENTRIES];   // Per-entry destination tag
    data_t      opa  [`RS_ENTRIES];   // Per-entry operand A
    data_t      opb  [`RS_ENTRIES];   // Per-entry operand B
    entry_vec_t grant;                // Winner, frees its entry

    // Each entry drives only its own slice
    modport entry  (output ready, free, func, tag, opa, opb, input grant);
    modport select (input  ready, func, tag, opa, opb, output grant);
endinterface

//--- source/rs_issue.sv
// Module rs_issue, rotating-priority pick of one ready entry and the issue register
`timescale 1ns/1ns
`include "rs_consts.svh"

module rs_issue import rs_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    rs_issue_if.select  issue_bus,
    output logic        issue_valid,  // Packet below is live
    output alu_func_t   issue_func,
    output rob_tag_t    issue_tag,
    output data_t       issue_opa,
    output data_t       issue_opb
);

    localparam int PTR_BITS = (`RS_ENTRIES > 1) ? $clog2(`RS_ENTRIES) : 1;
    localparam int LAST     = `RS_ENTRIES - 1;

    typedef logic [PTR_BITS-1:0] slot_t;

    slot_t      ptr;    // Highest-priority slot this cycle
    slot_t      win;    // Winning slot
    logic       found;  // Some slot is ready
    entry_vec_t grant;

    //////////////////////////////////////////////////
    // Selection searches upward from ptr with wrap
    //////////////////////////////////////////////////

    always_comb begin
        int cand;
        grant = '0;
        win   = ptr;
        found = 1'b0;
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            cand = (int'(ptr) + i) % `RS_ENTRIES;
            if (!found && issue_bus.ready[cand]) begin
                found       = 1'b1;
                win         = slot_t'(cand);
                grant[cand] = 1'b1;
            end
        end
    end

    assign issue_bus.grant = grant;  // Entry empties itself on this edge

    always_ff @(posedge clock) begin
        if (reset) begin
            ptr         <= '0;
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= found;
            if (found) ptr <= (int'(win) == LAST) ? '0 : win + slot_t'(1);  // Skip past winner
        end
    end

    // Issue packet holds its value when idle
    always_ff @(posedge clock) begin
        if (found) begin
            issue_func <= issue_bus.func[win];
            issue_tag  <= issue_bus.tag[win];
            issue_opa  <= issue_bus.opa[win];
            issue_opb  <= issue_bus.opb[win];
        end
    end

    // Granted slot empties and drops ready in the next cycle
    a_grant_onehot : assert property (
        @(posedge clock) disable iff (reset) |grant |=> (issue_bus.ready & $past(grant)) == '0
    ) else $error("rs_issue: granted entry still ready after issue");

endmodule

//--- source/rs_pkg.sv
// Package rs_pkg with value, tag and entry-vector types and the ALU function enum
`include "rs_consts.svh"

package rs_pkg;

    //////////////////////////////////////////////////
    // Vector types
    //////////////////////////////////////////////////

    typedef logic [`RS_DATA_BITS-1:0] data_t;      // Operand or result value
    typedef logic [`RS_TAG_BITS-1:0]  rob_tag_t;   // Destination or source tag
    typedef logic [`RS_ENTRIES-1:0]   entry_vec_t; // One bit per entry

    //////////////////////////////////////////////////
    // ALU functions
    //////////////////////////////////////////////////

    // Shifts take the low 5 bits of operand B, SLT is signed
    typedef enum logic [`RS_FUNC_BITS-1:0] {
        ALU_ADD,  // A + B
        ALU_SUB,  // A - B
        ALU_AND,  // Bitwise and
        ALU_OR,   // Bitwise or
        ALU_XOR,  // Bitwise xor
        ALU_SLL,  // Logical shift left
        ALU_SRL,  // Logical shift right
        ALU_SLT   // Signed less-than, 1 or 0
    } alu_func_t;

endpackage

//--- src.f
+incdir+source
source/rs_pkg.sv
source/rs_if.sv
source/rs_alloc.sv
source/rs_entry.sv
source/rs_issue.sv
source/alu_unit.sv
source/rs_cluster.sv
test/tb_clock.sv
test/rs_tb.sv

//--- test/rs_tb.sv
// Module rs_tb, random dispatch stimulus, result model, scoreboard and watchdog
`timescale 1ns/1ns
`include "rs_consts.svh"

module rs_tb import rs_pkg::*; ();

    localparam int PERIOD       = 10;
    localparam int RESET_CYCLES = 16;
    localparam int N_TRANS      = 300;                 // Instructions dispatched in total
    localparam int TAGS         = 1 << `RS_TAG_BITS;
    localparam int WATCHDOG     = N_TRANS * 40 + 200;  // Cycles before giving up

    logic      clock;
    logic      reset;
    logic      dispatch_valid;
    logic      dispatch_opa_valid;
    logic      dispatch_opb_valid;
    alu_func_t dispatch_func;
    rob_tag_t  dispatch_tag;
    data_t     dispatch_opa;
    data_t     dispatch_opb;
    logic      dispatch_ready;
    logic      complete_valid;
    rob_tag_t  complete_tag;
    data_t     complete_value;

    //////////////////////////////////////////////////
    // Model state by destination tag
    //////////////////////////////////////////////////

    logic      busy   [TAGS];  // Accepted with result not yet seen
    alu_func_t fn     [TAGS];
    logic      a_wait [TAGS];  // A still owed by a producer
    rob_tag_t  a_src  [TAGS];
    data_t     a_val  [TAGS];
    logic      b_wait [TAGS];
    rob_tag_t  b_src  [TAGS];
    data_t     b_val  [TAGS];
    data_t     res    [TAGS];  // Last result per tag

    rob_tag_t  last_tag;       // Newest offer heads the chains
    logic      offer_taken;    // Handshake completes at next edge
    integer    seed;
    int        n_offered, n_accepted, n_completed, bypass_hits;
    int        value_errors, other_errors;

    tb_clock #(.PERIOD(PERIOD)) u_clock (.clock(clock));

    rs_cluster DUT (
        .clock              (clock),
        .reset              (reset),
        .dispatch_valid     (dispatch_valid),
        .dispatch_opa_valid (dispatch_opa_valid),
        .dispatch_opb_valid (dispatch_opb_valid),
        .dispatch_func      (dispatch_func),
        .dispatch_tag       (dispatch_tag),
        .dispatch_opa       (dispatch_opa),
        .dispatch_opb       (dispatch_opb),
        .dispatch_ready     (dispatch_ready),
        .complete_valid     (complete_valid),
        .complete_tag       (complete_tag),
        .complete_value     (complete_value)
    );

    // ALU rules with shifts by B mod 32 and signed SLT
    function automatic data_t expected_result(alu_func_t f, data_t a, data_t b);
        int sh;
        sh = int'(b % 32);
        case (f)
            ALU_ADD: return a + b;
            ALU_SUB: return a + ~b + 1;  // Two's complement negate
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << sh;
            ALU_SRL: return a >> sh;
            ALU_SLT: begin
                if (a[`RS_DATA_BITS-1] != b[`RS_DATA_BITS-1])
                    return data_t'(a[`RS_DATA_BITS-1]);  // Negative one is smaller
                return data_t'(a < b);
            end
            default: return '0;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Scoreboard
    //////////////////////////////////////////////////

    task automatic accept_offer();
        rob_tag_t t;
        t = dispatch_tag;
        a_src[t]  = dispatch_opa[`RS_TAG_BITS-1:0];
        a_wait[t] = !dispatch_opa_valid && busy[a_src[t]];
        a_val[t]  = dispatch_opa_valid ? dispatch_opa : res[a_src[t]];
        b_src[t]  = dispatch_opb[`RS_TAG_BITS-1:0];
        b_wait[t] = !dispatch_opb_valid && busy[b_src[t]];
        b_val[t]  = dispatch_opb_valid ? dispatch_opb : res[b_src[t]];
        if (!dispatch_opa_valid && !a_wait[t]) bypass_hits++;  // Producer was on CDB
        if (!dispatch_opb_valid && !b_wait[t]) bypass_hits++;
        fn[t]   = dispatch_func;
        busy[t] = 1'b1;  // Set last since a source may share this tag
        n_accepted++;
        dispatch_valid = 1'b0;
    endtask

    task automatic check_completion();
        rob_tag_t x;
        data_t    want;
        x = complete_tag;
        if (!busy[x]) begin
            other_errors++;
            $display("error at %0t: completion for tag %0d, which is not in flight", $time, x);
        end else begin
            if (a_wait[x] || b_wait[x]) begin
                other_errors++;
                $display("error at %0t: tag %0d completed before its operands were produced",
                         $time, x);
            end
            want = expected_result(fn[x], a_val[x], b_val[x]);
            if (complete_value !== want) begin
                value_errors++;
                $display("error at %0t: complete_value tag %0d expected %h got %h",
                         $time, x, want, complete_value);
            end
            res[x]  = want;
            busy[x] = 1'b0;
            n_completed++;
            for (int t = 0; t < TAGS; t++) begin  // Wake consumers in the model
                if (busy[t] && a_wait[t] && a_src[t] == x) begin
                    a_val[t]  = want;
                    a_wait[t] = 1'b0;
                end
                if (busy[t] && b_wait[t] && b_src[t] == x) begin
                    b_val[t]  = want;
                    b_wait[t] = 1'b0;
                end
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    // Immediate value or a tag of an in-flight or broadcasting producer
    task automatic choose_operand(input logic chain, output data_t val, output logic is_value);
        int       roll;
        rob_tag_t s;
        roll     = $random(seed) & 7;
        val      = $random(seed);  // Upper bits stay random for tag operands
        is_value = 1'b1;
        if (complete_valid && roll < 2) begin
            val[`RS_TAG_BITS-1:0] = complete_tag;  // Same-cycle bypass
            is_value = 1'b0;
        end else if (chain && busy[last_tag] && roll < 6) begin
            val[`RS_TAG_BITS-1:0] = last_tag;
            is_value = 1'b0;
        end else if (roll < 4) begin
            s = rob_tag_t'($random(seed));
            for (int i = 0; i < TAGS; i++)
                if (!busy[s]) s = s + rob_tag_t'(1);
            if (busy[s]) begin
                val[`RS_TAG_BITS-1:0] = s;
                is_value = 1'b0;
            end
        end
    endtask

    task automatic make_offer(input logic chain);
        rob_tag_t t;
        t = rob_tag_t'($random(seed));
        for (int i = 0; i < TAGS; i++)
            if (busy[t]) t = t + rob_tag_t'(1);  // Settles on a free tag
        dispatch_tag  = t;
        dispatch_func = alu_func_t'(3'($random(seed)));
        choose_operand(chain, dispatch_opa, dispatch_opa_valid);
        choose_operand(chain, dispatch_opb, dispatch_opb_valid);
        dispatch_valid = 1'b1;
        last_tag = t;
        n_offered++;
    endtask

    // Producer gone and no bypass this edge so its value replaces the tag
    task automatic refresh_operands();
        rob_tag_t s;
        s = dispatch_opa[`RS_TAG_BITS-1:0];
        if (!dispatch_opa_valid && !busy[s]
            && !(complete_valid && complete_tag == s && dispatch_ready)) begin
            dispatch_opa       = res[s];
            dispatch_opa_valid = 1'b1;
        end
        s = dispatch_opb[`RS_TAG_BITS-1:0];
        if (!dispatch_opb_valid && !busy[s]
            && !(complete_valid && complete_tag == s && dispatch_ready)) begin
            dispatch_opb       = res[s];
            dispatch_opb_valid = 1'b1;
        end
    endtask

    // One cycle of sampling and driving at the falling edge
    task automatic step();
        logic stress;
        int   roll;
        @(negedge clock);
        stress = n_offered >= N_TRANS / 2;  // Second half keeps valid high
        roll   = $random(seed) & 3;
        if (offer_taken) accept_offer();
        if (complete_valid) check_completion();
        if (!dispatch_valid && n_offered < N_TRANS && (stress || roll != 0)) make_offer(stress);
        if (dispatch_valid) refresh_operands();
        offer_taken = dispatch_valid && dispatch_ready;  // Ready holds until next edge
    endtask

    initial begin
        seed               = 32'h96ee;
        reset              = 1'b1;
        dispatch_valid     = 1'b0;
        dispatch_opa_valid = 1'b0;
        dispatch_opb_valid = 1'b0;
        dispatch_func      = ALU_ADD;
        dispatch_tag       = '0;
        dispatch_opa       = '0;
        dispatch_opb       = '0;
        for (int t = 0; t < TAGS; t++) begin
            busy[t]   = 1'b0;
            a_wait[t] = 1'b0;
            b_wait[t] = 1'b0;
            res[t]    = '0;
        end
        last_tag     = '0;
        offer_taken  = 1'b0;
        n_offered    = 0;
        n_accepted   = 0;
        n_completed  = 0;
        bypass_hits  = 0;
        value_errors = 0;
        other_errors = 0;

        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        if (dispatch_ready !== 1'b1) begin
            value_errors++;
            $display("error at %0t: dispatch_ready expected 1 got %b", $time, dispatch_ready);
        end
        if (complete_valid !== 1'b0) begin
            value_errors++;
            $display("error at %0t: complete_valid expected 0 got %b", $time, complete_valid);
        end

        while (n_completed < N_TRANS) step();
        repeat (20) step();  // Drain where any late completion is a stray
        if (bypass_hits == 0) begin
            other_errors++;
            $display("error: no dispatch exercised the same-cycle CDB bypass");
        end

        $display("%0d accepted, %0d completed, %0d bypassed, %0d value errors, %0d other errors",
                 n_accepted, n_completed, bypass_hits, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG * PERIOD);
        $display("timeout: %0d of %0d instructions completed within %0d cycles",
                 n_completed, N_TRANS, WATCHDOG);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- test/tb_clock.sv
// Module tb_clock, free-running testbench clock source
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD = 10  // Clock period in ns
) (
    output logic clock
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;  // Rising edges at 5, 15, 25 ns
    end

endmodule
